// File: alu.sv
`timescale 1ns/1ps

// integer alu, purely combinational
module alu import isa_pkg::*; (
	input  logic [xlen-1:0] opa,
	input  logic [xlen-1:0] opb,
	input  alu_select       func,
	output logic [xlen-1:0] result
);

	logic [4:0] shamt;   // rv32 shifts only look at 5 bits
	logic       lt_s;    // signed less than
	logic       lt_u;    // unsigned less than

	assign shamt = opb[4:0];
	assign lt_s  = $signed(opa) < $signed(opb);
	assign lt_u  = opa < opb;

	//////////////////////////////////////////////////
	// operation select
	//////////////////////////////////////////////////

	always_comb begin
		case (func)
			ALU_ADD:  result = opa + opb;
			ALU_SUB:  result = opa - opb;
			ALU_AND:  result = opa & opb;
			ALU_SLT:  result = xlen'(lt_s);   // 0 or 1
			ALU_SLTU: result = xlen'(lt_u);
			ALU_OR:   result = opa | opb;
			ALU_XOR:  result = opa ^ opb;
			ALU_SRL:  result = opa >> shamt;  // zero fill
			ALU_SLL:  result = opa << shamt;
			ALU_SRA:  result = $signed(opa) >>> shamt; // sign fill
			// stores get turned into adds before they reach here,
			// anything else is a decode bug upstream
			default:  result = alu_bad_result;
		endcase
	end

endmodule

// File: alu_ex_assert.sv
`timescale 1ns/1ps

// protocol properties around the execute path
module alu_ex_assert import pipe_pkg::*; (
	input logic           clock,
	input logic           reset,
	input issue_packet    issue_in,
	input logic           issue_ready,
	input logic           cdb_grant,
	input complete_packet cdb_out,
	input logic           sq_write,
	input issue_packet    slot_pkt
);

	// an offered op is not taken while the port says not ready
	issue_hold: assert property (@(posedge clock) disable iff (reset)
		issue_in.valid && !issue_ready |=> $stable(slot_pkt))
		else $error("slot loaded while issue_ready was low");

	cdb_hold: assert property (@(posedge clock) disable iff (reset)
		cdb_out.valid && !cdb_grant |=> $stable(cdb_out)) // head waits for grant
		else $error("cdb_out changed before it was granted");

	// store leaves the slot on its write cycle, never written twice
	sq_once: assert property (@(posedge clock) disable iff (reset)
		sq_write |=> !(sq_write && $stable(slot_pkt)))
		else $error("sq_write repeated for a held store");

	reset_clear: assert property (@(posedge clock)
		reset |=> !cdb_out.valid) // buffer empty out of reset
		else $error("cdb_out.valid high right after reset");

endmodule

bind alu_ex_top alu_ex_assert assert0 (
	.clock       (clock),
	.reset       (reset),
	.issue_in    (issue_in),
	.issue_ready (issue_ready),
	.cdb_grant   (cdb_grant),
	.cdb_out     (cdb_out),
	.sq_write    (sq_write),
	.slot_pkt    (slot_pkt)
);

// File: alu_ex_top.sv
`timescale 1ns/1ps

// alu execute path: issue slot, alu unit, completion buffer
module alu_ex_top import pipe_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  issue_packet         issue_in,
	output logic                issue_ready,
	input  logic                cdb_grant,
	output complete_packet      cdb_out,
	output logic                sq_write,
	output sq_entry             sq_pkt,
	output logic [sq_idx_w-1:0] sq_idx
);

	issue_packet    slot_pkt;
	complete_packet fu_out;
	logic           fu_ready;       // ~complete_stall, back to the slot
	logic           complete_stall; // buffer full

	issue_slot slot0 (
		.clock       (clock),
		.reset       (reset),
		.issue_in    (issue_in),
		.fu_ready    (fu_ready),
		.issue_ready (issue_ready),
		.slot_pkt    (slot_pkt)
	);

	fu_alu fu0 (
		.clock          (clock),
		.reset          (reset),
		.slot_pkt       (slot_pkt),
		.complete_stall (complete_stall),
		.fu_ready       (fu_ready),
		.fu_out         (fu_out),
		.sq_write       (sq_write),
		.sq_pkt         (sq_pkt),
		.sq_idx         (sq_idx)
	);

	complete_buffer cbuf0 (
		.clock          (clock),
		.reset          (reset),
		.fu_out         (fu_out),
		.cdb_grant      (cdb_grant),
		.complete_stall (complete_stall),
		.cdb_out        (cdb_out)
	);

endmodule

// File: complete_buffer.sv
`timescale 1ns/1ps

// two entry completion fifo in front of the cdb
module complete_buffer import pipe_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	input  complete_packet fu_out,
	input  logic           cdb_grant,
	output logic           complete_stall,
	output complete_packet cdb_out
);

	complete_packet        mem [cbuf_depth];
	logic [cbuf_ptr_w-1:0] head;  // oldest entry
	logic [cbuf_ptr_w-1:0] tail;  // next free entry
	logic [cbuf_cnt_w-1:0] count;
	logic                  full;
	logic                  empty;
	logic                  push;
	logic                  pop;

	// circular wrap at the end of the array
	function automatic logic [cbuf_ptr_w-1:0] ptr_next(input logic [cbuf_ptr_w-1:0] ptr);
		if (ptr == cbuf_ptr_w'(cbuf_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full           = count == cbuf_cnt_w'(cbuf_depth);
	assign empty          = count == '0;
	assign push           = fu_out.valid & ~full;
	assign pop            = ~empty & cdb_grant; // head taken by the cdb
	assign complete_stall = full;               // holds the unit register

	// head shows up on the bus the cycle after it was written
	always_comb begin
		cdb_out       = mem[head];
		cdb_out.valid = ~empty;
	end

	//////////////////////////////////////////////////
	// pointers and count
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push) tail <= ptr_next(tail);
			if (pop)  head <= ptr_next(head);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none or both
			endcase
		end
	end

	// storage, payload only
	always_ff @(posedge clock) begin
		if (push) begin
			mem[tail] <= fu_out;
		end
	end

endmodule

// File: fu_alu.sv
`timescale 1ns/1ps

// alu functional unit: operand muxes, store builder, result register
module fu_alu import isa_pkg::*; import pipe_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  issue_packet         slot_pkt,
	input  logic                complete_stall, // completion buffer full
	output logic                fu_ready,
	output complete_packet      fu_out,
	output logic                sq_write,
	output sq_entry             sq_pkt,
	output logic [sq_idx_w-1:0] sq_idx
);

	logic [xlen-1:0] opa;
	logic [xlen-1:0] opb;
	logic [xlen-1:0] alu_result; // also the store address
	logic [xlen-1:0] store_val;
	logic            is_store;
	alu_select       alu_func;
	complete_packet  result;

	assign fu_ready = ~complete_stall;
	assign is_store = slot_pkt.func >= SB;
	assign alu_func = is_store ? ALU_ADD : slot_pkt.func; // ea = rs1 + imm

	//////////////////////////////////////////////////
	// operand muxes
	//////////////////////////////////////////////////

	always_comb begin
		case (slot_pkt.opa_sel)
			OPA_IS_RS1: opa = slot_pkt.r1_value;
			OPA_IS_NPC: opa = slot_pkt.npc;
			OPA_IS_PC:  opa = slot_pkt.pc;
			default:    opa = '0; // OPA_IS_ZERO
		endcase
	end

	always_comb begin
		case (slot_pkt.opb_sel)
			OPB_IS_RS2:   opb = slot_pkt.r2_value;
			OPB_IS_I_IMM: opb = imm_i(slot_pkt.inst);
			OPB_IS_S_IMM: opb = imm_s(slot_pkt.inst);
			OPB_IS_B_IMM: opb = imm_b(slot_pkt.inst);
			OPB_IS_U_IMM: opb = imm_u(slot_pkt.inst);
			OPB_IS_J_IMM: opb = imm_j(slot_pkt.inst);
			default:      opb = opb_bad_value; // two codes unused
		endcase
	end

	alu alu0 (
		.opa    (opa),
		.opb    (opb),
		.func   (alu_func),
		.result (alu_result)
	);

	//////////////////////////////////////////////////
	// store queue entry
	//////////////////////////////////////////////////

	assign store_val = slot_pkt.r2_value;
	assign sq_idx    = slot_pkt.sq_tail;
	// one pulse per store, the slot moves on when fu_ready is high
	assign sq_write  = slot_pkt.valid & is_store & fu_ready;

	always_comb begin
		sq_pkt.ready    = 1'b1;                       // addr and data both known
		sq_pkt.addr     = {alu_result[xlen-1:2], 2'b00}; // word aligned
		sq_pkt.data     = '0;                         // unused lanes stay zero
		sq_pkt.usebytes = 4'b0000;
		case (slot_pkt.func)
			SB: begin
				// byte goes to the lane picked by the low address bits
				sq_pkt.usebytes = 4'b0001 << alu_result[1:0];
				sq_pkt.data     = xlen'(store_val[7:0]) << {alu_result[1:0], 3'b000};
			end
			SH: begin
				if (alu_result[1:0] == 2'b00) begin
					sq_pkt.usebytes   = 4'b0011;
					sq_pkt.data[15:0] = store_val[15:0];
				end else if (alu_result[1:0] == 2'b10) begin
					sq_pkt.usebytes    = 4'b1100;
					sq_pkt.data[31:16] = store_val[15:0];
				end // misaligned half leaves usebytes zero
			end
			SW: begin
				sq_pkt.usebytes = 4'b1111;
				sq_pkt.data     = store_val;
			end
			default: begin
				sq_pkt.usebytes = 4'b0000; // not a store
			end
		endcase
	end

	//////////////////////////////////////////////////
	// complete packet
	//////////////////////////////////////////////////

	always_comb begin
		result.valid          = slot_pkt.valid;
		result.halt           = slot_pkt.halt;
		result.if_take_branch = 1'b0; // no branch resolution in this unit
		result.target_pc      = '0;
		result.dest_pr        = slot_pkt.dest_pr;
		result.rob_entry      = slot_pkt.rob_entry;
		result.dest_value     = alu_result;
	end

	// holds while the buffer is full so nothing gets lost
	always_ff @(posedge clock) begin
		if (reset) begin
			fu_out.valid <= 1'b0;
		end else if (!complete_stall) begin
			fu_out <= result;
		end
	end

endmodule

// File: isa_pkg.sv
package isa_pkg;

	localparam int xlen = 32; // fixed by the ISA

	// markers that show up when a code or select was never decoded
	localparam logic [xlen-1:0] alu_bad_result = 32'hfacebeec;
	localparam logic [xlen-1:0] opb_bad_value  = 32'hfacefeed;

	//////////////////////////////////////////////////
	// opcodes and operand selects
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_SLT,  // signed compare
		ALU_SLTU, // unsigned compare
		ALU_OR,
		ALU_XOR,
		ALU_SRL,
		ALU_SLL,
		ALU_SRA,
		SB,       // stores start here, anything >= SB is a store
		SH,
		SW
	} alu_select;

	typedef enum logic [1:0] {
		OPA_IS_RS1,
		OPA_IS_NPC,
		OPA_IS_PC,
		OPA_IS_ZERO
	} opa_select;

	typedef enum logic [2:0] {
		OPB_IS_RS2,
		OPB_IS_I_IMM,
		OPB_IS_S_IMM,
		OPB_IS_B_IMM,
		OPB_IS_U_IMM,
		OPB_IS_J_IMM
	} opb_select;

	//////////////////////////////////////////////////
	// immediate extraction, RV32 formats
	//////////////////////////////////////////////////

	function automatic logic [xlen-1:0] imm_i(input logic [31:0] inst);
		return {{21{inst[31]}}, inst[30:20]};
	endfunction

	function automatic logic [xlen-1:0] imm_s(input logic [31:0] inst);
		return {{21{inst[31]}}, inst[30:25], inst[11:7]};
	endfunction

	function automatic logic [xlen-1:0] imm_b(input logic [31:0] inst);
		return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}; // bit 0 implied
	endfunction

	function automatic logic [xlen-1:0] imm_u(input logic [31:0] inst);
		return {inst[31:12], 12'b0}; // upper 20, low bits zero
	endfunction

	function automatic logic [xlen-1:0] imm_j(input logic [31:0] inst);
		return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	endfunction

endpackage

// File: issue_slot.sv
`timescale 1ns/1ps

// one entry input register in front of the alu unit
module issue_slot import pipe_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  issue_packet issue_in,
	input  logic        fu_ready,    // unit can take the slot contents
	output logic        issue_ready,
	output issue_packet slot_pkt
);

	logic advance; // slot moves on this edge

	// the slot empties into the unit exactly when the unit is ready,
	// so it can always refill on the same edge
	assign advance     = fu_ready;
	assign issue_ready = advance;

	//////////////////////////////////////////////////
	// slot register
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			slot_pkt.valid <= 1'b0; // empty after reset
		end else if (advance) begin
			slot_pkt.valid <= issue_in.valid; // low loads a bubble
		end
	end

	// payload only moves with the slot, no reset needed
	always_ff @(posedge clock) begin
		if (advance) begin
			slot_pkt.halt      <= issue_in.halt;
			slot_pkt.inst      <= issue_in.inst;
			slot_pkt.pc        <= issue_in.pc;
			slot_pkt.npc       <= issue_in.npc;
			slot_pkt.r1_value  <= issue_in.r1_value;
			slot_pkt.r2_value  <= issue_in.r2_value;
			slot_pkt.opa_sel   <= issue_in.opa_sel;
			slot_pkt.opb_sel   <= issue_in.opb_sel;
			slot_pkt.func      <= issue_in.func;
			slot_pkt.dest_pr   <= issue_in.dest_pr;
			slot_pkt.rob_entry <= issue_in.rob_entry;
			slot_pkt.sq_tail   <= issue_in.sq_tail;
		end
	end

endmodule

// File: pipe_pkg.sv
package pipe_pkg;

	import isa_pkg::*;

	// index widths into the surrounding structures
	localparam int rob_idx_w  = 5;  // 32 rob entries
	localparam int preg_idx_w = 6;  // 64 physical regs
	localparam int sq_idx_w   = 3;  // 8 store queue slots

	// completion buffer sizing
	localparam int cbuf_depth = 2;
	localparam int cbuf_ptr_w = 1;
	localparam int cbuf_cnt_w = 2; // holds 0..cbuf_depth

	//////////////////////////////////////////////////
	// packets between stages
	//////////////////////////////////////////////////

	// issue port into the alu unit
	typedef struct packed {
		logic                  valid;
		logic                  halt;
		logic [31:0]           inst;
		logic [xlen-1:0]       pc;
		logic [xlen-1:0]       npc;
		logic [xlen-1:0]       r1_value;
		logic [xlen-1:0]       r2_value;
		opa_select             opa_sel;
		opb_select             opb_sel;
		alu_select             func;
		logic [preg_idx_w-1:0] dest_pr;
		logic [rob_idx_w-1:0]  rob_entry;
		logic [sq_idx_w-1:0]   sq_tail; // where a store lands
	} issue_packet;

	// result broadcast on the cdb
	typedef struct packed {
		logic                  valid;
		logic                  halt;
		logic                  if_take_branch; // always low here
		logic [xlen-1:0]       target_pc;
		logic [preg_idx_w-1:0] dest_pr;
		logic [rob_idx_w-1:0]  rob_entry;
		logic [xlen-1:0]       dest_value;
	} complete_packet;

	// one store queue entry, word aligned
	typedef struct packed {
		logic            ready;
		logic [xlen-1:0] addr;
		logic [xlen-1:0] data;
		logic [3:0]      usebytes; // one bit per byte lane
	} sq_entry;

endpackage

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
verilator --binary --assert --timing --top-module tb_alu_ex -f sim.f -o tb_alu_ex
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
out=$(./obj_dir/tb_alu_ex)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if echo "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

// File: sim.f
isa_pkg.sv
pipe_pkg.sv
alu.sv
issue_slot.sv
fu_alu.sv
complete_buffer.sv
alu_ex_top.sv
alu_ex_assert.sv
tb_alu_ex.sv

// File: tb_alu_ex.sv
`timescale 1ns/1ps

module tb_alu_ex import isa_pkg::*, pipe_pkg::*;;

	// one row of the stimulus table
	typedef struct packed {
		alu_select             func;
		opa_select             opa_sel;
		opb_select             opb_sel;
		logic [31:0]           r1;
		logic [31:0]           r2;
		logic [31:0]           pc;
		logic [31:0]           inst;
		logic [preg_idx_w-1:0] dest_pr;
		logic [rob_idx_w-1:0]  rob_entry;
	} op_t;

	logic                clock;
	logic                reset;
	issue_packet         issue_in;
	logic                issue_ready;
	logic                cdb_grant;
	complete_packet      cdb_out;
	logic                sq_write;
	sq_entry             sq_pkt;
	logic [sq_idx_w-1:0] sq_idx;

	int  cyc = 0;
	int  limit = 1000000;   // real value set once the table exists
	int  errors = 0;
	int  phase = 0;         // 0 full grant, 1 random grant
	bit  stall_seen = 0;
	int  stores_issued = 0;
	int  sq_seen = 0;
	op_t ops[$];
	complete_packet      exp_cdb[$]; // in issue order
	int                  exp_cyc[$];
	sq_entry             exp_sq[$];
	logic [sq_idx_w-1:0] exp_idx[$];

	alu_ex_top dut0 (
		.clock       (clock),
		.reset       (reset),
		.issue_in    (issue_in),
		.issue_ready (issue_ready),
		.cdb_grant   (cdb_grant),
		.cdb_out     (cdb_out),
		.sq_write    (sq_write),
		.sq_pkt      (sq_pkt),
		.sq_idx      (sq_idx)
	);

	always #4 clock = ~clock; // 8 ns period

	always @(posedge clock) begin
		cyc <= cyc + 1;
		if (cyc > limit) begin
			$display("timeout after %0d cycles, results still outstanding", cyc);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// reference model, straight from the RV32 rules
	//////////////////////////////////////////////////

	function automatic logic [31:0] opa_of(input op_t o);
		case (o.opa_sel)
			OPA_IS_RS1: return o.r1;
			OPA_IS_NPC: return o.pc + 32'd4;
			OPA_IS_PC:  return o.pc;
			default:    return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] opb_of(input op_t o);
		case (o.opb_sel)
			OPB_IS_RS2:   return o.r2;
			OPB_IS_I_IMM: return {{20{o.inst[31]}}, o.inst[31:20]};
			OPB_IS_S_IMM: return {{20{o.inst[31]}}, o.inst[31:25], o.inst[11:7]};
			OPB_IS_B_IMM: return {{19{o.inst[31]}}, o.inst[31], o.inst[7], o.inst[30:25],
				o.inst[11:8], 1'b0};
			OPB_IS_U_IMM: return {o.inst[31:12], 12'h000};
			default:      return {{11{o.inst[31]}}, o.inst[31], o.inst[19:12], o.inst[20],
				o.inst[30:21], 1'b0}; // j format
		endcase
	endfunction

	function automatic logic [31:0] ref_value(input op_t o);
		logic [31:0] a;
		logic [31:0] b;
		a = opa_of(o);
		b = opb_of(o);
		case (o.func)
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU: return {31'b0, a < b};
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SRL:  return a >> b[4:0];
			ALU_SLL:  return a << b[4:0];
			ALU_SRA:  return 32'($signed(a) >>> b[4:0]);
			default:  return a + b; // add, and the address of a store
		endcase
	endfunction

	function automatic sq_entry ref_store(input op_t o);
		sq_entry     s;
		logic [31:0] ea;
		ea = opa_of(o) + opb_of(o);
		s.ready = 1'b1;
		s.addr = {ea[31:2], 2'b00};
		s.usebytes = 4'b0000;
		s.data = 32'h0;
		if (o.func == SB) begin
			s.usebytes = 4'b0001 << ea[1:0];
			s.data = {24'h0, o.r2[7:0]} << {ea[1:0], 3'b000};
		end else if (o.func == SH && ea[1:0] == 2'b00) begin
			s.usebytes = 4'b0011;
			s.data = {16'h0, o.r2[15:0]};
		end else if (o.func == SH && ea[1:0] == 2'b10) begin
			s.usebytes = 4'b1100;
			s.data = {o.r2[15:0], 16'h0};
		end else if (o.func == SW) begin
			s.usebytes = 4'b1111;
			s.data = o.r2;
		end
		return s;
	endfunction

	task automatic add_op(input alu_select f, input opa_select a, input opb_select b,
			input logic [31:0] r1, input logic [31:0] r2, input logic [31:0] pc,
			input logic [31:0] inst);
		op_t o;
		o.func = f;
		o.opa_sel = a;
		o.opb_sel = b;
		o.r1 = r1;
		o.r2 = r2;
		o.pc = pc;
		o.inst = inst;
		o.dest_pr = 6'(ops.size() + 10);
		o.rob_entry = 5'(ops.size());
		ops.push_back(o);
	endtask

	task automatic build_table();
		add_op(ALU_ADD,  OPA_IS_RS1,  OPB_IS_RS2,   32'd5,        32'd7,        0, 0);
		add_op(ALU_ADD,  OPA_IS_RS1,  OPB_IS_RS2,   32'h7fffffff, 32'd1,        0, 0);
		add_op(ALU_SUB,  OPA_IS_RS1,  OPB_IS_RS2,   32'd3,        32'd5,        0, 0);
		add_op(ALU_AND,  OPA_IS_RS1,  OPB_IS_RS2,   32'hf0f0ff00, 32'h3c3c0ff0, 0, 0);
		add_op(ALU_OR,   OPA_IS_RS1,  OPB_IS_RS2,   32'hf0f0ff00, 32'h3c3c0ff0, 0, 0);
		add_op(ALU_XOR,  OPA_IS_RS1,  OPB_IS_RS2,   32'hf0f0ff00, 32'h3c3c0ff0, 0, 0);
		add_op(ALU_SLT,  OPA_IS_RS1,  OPB_IS_RS2,   32'hffffffff, 32'd1,        0, 0);
		add_op(ALU_SLTU, OPA_IS_RS1,  OPB_IS_RS2,   32'hffffffff, 32'd1,        0, 0);
		add_op(ALU_SLTU, OPA_IS_RS1,  OPB_IS_RS2,   32'd1,        32'hffffffff, 0, 0);
		add_op(ALU_SRL,  OPA_IS_RS1,  OPB_IS_RS2,   32'h80000000, 32'd0,        0, 0);
		add_op(ALU_SRL,  OPA_IS_RS1,  OPB_IS_RS2,   32'h80000000, 32'd31,       0, 0);
		add_op(ALU_SLL,  OPA_IS_RS1,  OPB_IS_RS2,   32'h00000001, 32'd31,       0, 0);
		add_op(ALU_SRA,  OPA_IS_RS1,  OPB_IS_RS2,   32'h80000000, 32'd31,       0, 0);
		add_op(ALU_SRA,  OPA_IS_RS1,  OPB_IS_RS2,   32'h80000000, 32'd33,       0, 0);
		// operand selects, imm fields picked to be negative where they can
		add_op(ALU_ADD,  OPA_IS_PC,   OPB_IS_I_IMM, 0, 0, 32'h00001000, 32'hfff00093);
		add_op(ALU_ADD,  OPA_IS_NPC,  OPB_IS_U_IMM, 0, 0, 32'h00002000, 32'h12345037);
		add_op(ALU_ADD,  OPA_IS_ZERO, OPB_IS_B_IMM, 0, 0, 32'h00003000, 32'h80000063);
		add_op(ALU_ADD,  OPA_IS_RS1,  OPB_IS_J_IMM, 32'd64, 0, 0, 32'hffdff06f);
		add_op(ALU_ADD,  OPA_IS_ZERO, OPB_IS_S_IMM, 0, 0, 0, 32'hfe000fa3);
		// stores, every byte lane then halves and a word
		add_op(SB, OPA_IS_RS1, OPB_IS_S_IMM, 32'd100, 32'ha1b2c3d4, 0, 0);
		add_op(SB, OPA_IS_RS1, OPB_IS_S_IMM, 32'd101, 32'ha1b2c3d4, 0, 0);
		add_op(SB, OPA_IS_RS1, OPB_IS_S_IMM, 32'd102, 32'ha1b2c3d4, 0, 0);
		add_op(SB, OPA_IS_RS1, OPB_IS_S_IMM, 32'd103, 32'ha1b2c3d4, 0, 0);
		add_op(SH, OPA_IS_RS1, OPB_IS_S_IMM, 32'd200, 32'h5566beef, 0, 0);
		add_op(SH, OPA_IS_RS1, OPB_IS_S_IMM, 32'd202, 32'h5566beef, 0, 0);
		add_op(SW, OPA_IS_RS1, OPB_IS_S_IMM, 32'd304, 32'hcafef00d, 0, 32'hfe000e23);
	endtask

	//////////////////////////////////////////////////
	// scoreboard
	//////////////////////////////////////////////////

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("** Error at %0d ns: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// one falling edge: new grant, then look at what moves on the next rise
	task automatic tick();
		complete_packet e;
		sq_entry        s;
		int             t0;
		@(negedge clock);
		cdb_grant = (phase == 0) ? 1'b1 : ($urandom % 4 == 0);
		if (!issue_ready) stall_seen = 1'b1;
		if (cdb_out.valid && cdb_grant) begin
			if (exp_cdb.size() == 0) begin
				$display("completion on cdb_out at %0d ns with nothing outstanding", $time);
				errors++;
			end else begin
				e = exp_cdb.pop_front();
				t0 = exp_cyc.pop_front();
				check_val("cdb_out.halt", 32'(e.halt), 32'(cdb_out.halt));
				check_val("cdb_out.if_take_branch", 0, 32'(cdb_out.if_take_branch));
				check_val("cdb_out.target_pc", 0, cdb_out.target_pc);
				check_val("cdb_out.dest_pr", 32'(e.dest_pr), 32'(cdb_out.dest_pr));
				check_val("cdb_out.rob_entry", 32'(e.rob_entry), 32'(cdb_out.rob_entry));
				check_val("cdb_out.dest_value", e.dest_value, cdb_out.dest_value);
				if (phase == 0) check_val("issue to cdb latency", 2, cyc - t0);
			end
		end
		if (sq_write) begin
			sq_seen++;
			if (exp_sq.size() == 0) begin
				$display("sq_write at %0d ns without a store outstanding", $time);
				errors++;
			end else begin
				s = exp_sq.pop_front();
				check_val("sq_idx", 32'(exp_idx.pop_front()), 32'(sq_idx));
				check_val("sq_pkt.ready", 32'(s.ready), 32'(sq_pkt.ready));
				check_val("sq_pkt.addr", s.addr, sq_pkt.addr);
				check_val("sq_pkt.data", s.data, sq_pkt.data);
				check_val("sq_pkt.usebytes", 32'(s.usebytes), 32'(sq_pkt.usebytes));
			end
		end
	endtask

	// present one op, hold it until the slot takes it
	task automatic issue_op(input op_t o);
		issue_packet    p;
		complete_packet e;
		p = '0;
		p.valid = 1'b1;
		p.halt = o.rob_entry[0];
		p.inst = o.inst;
		p.pc = o.pc;
		p.npc = o.pc + 32'd4;
		p.r1_value = o.r1;
		p.r2_value = o.r2;
		p.opa_sel = o.opa_sel;
		p.opb_sel = o.opb_sel;
		p.func = o.func;
		p.dest_pr = o.dest_pr;
		p.rob_entry = o.rob_entry;
		p.sq_tail = o.rob_entry[2:0];
		issue_in = p;
		while (!issue_ready) tick();
		e = '0;
		e.valid = 1'b1;
		e.halt = p.halt;
		e.dest_pr = o.dest_pr;
		e.rob_entry = o.rob_entry;
		e.dest_value = ref_value(o);
		exp_cdb.push_back(e);
		exp_cyc.push_back(cyc + 1); // accepted on the coming rise
		if (o.func >= SB) begin
			exp_sq.push_back(ref_store(o));
			exp_idx.push_back(p.sq_tail);
			stores_issued++;
		end
		tick();
	endtask

	initial begin
		void'($urandom(32'h65a9e193));
		clock = 1'b0;
		reset = 1'b1;
		issue_in = '0;
		cdb_grant = 1'b0;
		build_table();
		limit = 2 * ops.size() * 20 + 100;
		repeat (8) @(negedge clock);
		reset = 1'b0;
		tick();
		check_val("cdb_out.valid after reset", 0, 32'(cdb_out.valid));
		check_val("sq_write after reset", 0, 32'(sq_write));
		check_val("issue_ready after reset", 1, 32'(issue_ready));
		for (phase = 0; phase < 2; phase++) begin
			foreach (ops[i]) issue_op(ops[i]);
			issue_in.valid = 1'b0;
			while (exp_cdb.size() > 0 || exp_sq.size() > 0) tick();
		end
		tick(); // last pop lands on this rise
		check_val("cdb_out.valid when drained", 0, 32'(cdb_out.valid));
		check_val("sq_write count", 32'(stores_issued), 32'(sq_seen));
		assert (stall_seen) else begin
			$display("issue_ready never fell under random grant");
			errors++;
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
